/* common/mem_pkg.sv */
`default_nettype none

// Memory map of the data memory seen by the memory-access stage
package mem_pkg;

	// Word address width, two banks of 512 words
	localparam int WORD_ADDR_W = 10;

	// Byte lanes in one data word
	localparam int LANES = 4;

	// Bits of a lane
	localparam int BYTE_W = 8;

	// Full data word
	localparam int WORD_W = LANES * BYTE_W;

	// Low byte-address bits that select the lane
	localparam int BYTE_OFS_W = $clog2(LANES);

	// The bank is always picked by the top word-address bit,
	// so any word address width splits into two equal halves

endpackage

`default_nettype wire

/* common/lsu_pkg.sv */
`default_nettype none

// Load/store encodings and the lane views of a data word
package lsu_pkg;

	// RV32 funct3 for loads
	typedef enum logic [2:0] {
		LB  = 3'b000,
		LH  = 3'b001,
		LW  = 3'b010,
		LBU = 3'b100,
		LHU = 3'b101
	} funct3_e;

	// Store codes share the load encodings
	localparam funct3_e SB = LB;
	localparam funct3_e SH = LH;
	localparam funct3_e SW = LW;

	// One strobe bit per byte lane
	typedef logic [mem_pkg::LANES-1:0] strb_t;

	// Same 32 bits, three ways to slice them
	typedef union packed {
		logic [mem_pkg::WORD_W-1:0]                          word;
		logic [mem_pkg::LANES/2-1:0][2*mem_pkg::BYTE_W-1:0]  halves;   // [0] is low half
		logic [mem_pkg::LANES-1:0][mem_pkg::BYTE_W-1:0]      bytes;    // [0] is lane 0
	} mem_word_u;

endpackage

`default_nettype wire

/* datamem/datamem.sv */
`timescale 1ns/1ps
`default_nettype none

// Two-bank data memory, core port plus protocol controller port
module datamem #(
	parameter int ADDR_W = mem_pkg::WORD_ADDR_W
) (
	input  wire                         clk,

	// Core side
	input  wire  [ADDR_W-1:0]           core_addr,
	input  wire  lsu_pkg::strb_t        core_strb,
	input  wire  [mem_pkg::WORD_W-1:0]  core_wdata,
	output logic [mem_pkg::WORD_W-1:0]  core_rdata,

	// Protocol controller side
	input  wire  [ADDR_W-1:0]           con_addr,
	input  wire  lsu_pkg::strb_t        con_strb,
	input  wire  [mem_pkg::WORD_W-1:0]  con_wdata,
	output logic [mem_pkg::WORD_W-1:0]  con_rdata
);

	localparam int BANK_WORDS = 2 ** (ADDR_W - 1);

	// Bank 0 is the lower half of the map, bank 1 the upper
	lsu_pkg::mem_word_u mem [0:1][0:BANK_WORDS-1];

	logic              core_bank;
	logic [ADDR_W-2:0] core_idx;
	logic              con_bank;
	logic [ADDR_W-2:0] con_idx;

	lsu_pkg::mem_word_u core_wd;
	lsu_pkg::mem_word_u con_wd;

	assign core_bank = core_addr[ADDR_W-1];   // Top bit picks the bank
	assign core_idx  = core_addr[ADDR_W-2:0];
	assign con_bank  = con_addr[ADDR_W-1];
	assign con_idx   = con_addr[ADDR_W-2:0];

	assign core_wd = core_wdata;
	assign con_wd  = con_wdata;

	// Combinational reads, either port from either bank
	assign core_rdata = mem[core_bank][core_idx].word;
	assign con_rdata  = mem[con_bank][con_idx].word;

	// Byte-masked writes
	// Lanes with a clear strobe bit keep their old value
	always_ff @(posedge clk) begin
		for (int l = 0; l < mem_pkg::LANES; l++) begin
			if (core_strb[l])
				mem[core_bank][core_idx].bytes[l] <= core_wd.bytes[l];
			if (con_strb[l])
				mem[con_bank][con_idx].bytes[l] <= con_wd.bytes[l];
		end
	end

	// Only SB, SH, SW or idle shapes are legal
	property legal_strb(logic [mem_pkg::LANES-1:0] s);
		s inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
		          4'b0011, 4'b1100, 4'b1111};
	endproperty

	a_core_strb: assert property (@(posedge clk) legal_strb(core_strb))
		else $error("datamem: illegal core strobe %b", core_strb);

	a_con_strb: assert property (@(posedge clk) legal_strb(con_strb))
		else $error("datamem: illegal controller strobe %b", con_strb);

	// No arbitration here, the core and the controller must not collide
	a_no_collide: assert property (@(posedge clk)
		!((|core_strb) && (|con_strb) && (core_addr == con_addr)))
		else $error("datamem: both ports write word %h", core_addr);

endmodule

`default_nettype wire

/* logic/store_align.sv */
`timescale 1ns/1ps
`default_nettype none

// Stage 1 of the memory-access stage
// Turns a byte-addressed request into word address, lane strobes and lane data
module store_align #(
	parameter int ADDR_W = mem_pkg::WORD_ADDR_W
) (
	input  wire                                    clk,
	input  wire                                    rst_n,

	input  wire                                    req_valid,
	input  wire                                    req_write,
	input  wire  lsu_pkg::funct3_e                 req_funct3,
	input  wire  [ADDR_W+mem_pkg::BYTE_OFS_W-1:0]  req_addr,   // Byte address
	input  wire  [mem_pkg::WORD_W-1:0]             req_wdata,

	output logic                                   s1_valid,
	output logic                                   s1_load,
	output lsu_pkg::funct3_e                       s1_funct3,
	output logic [mem_pkg::BYTE_OFS_W-1:0]         s1_lane,
	output logic [ADDR_W-1:0]                      s1_word_addr,
	output lsu_pkg::strb_t                         s1_strb,
	output logic [mem_pkg::WORD_W-1:0]             s1_wdata,
	output logic                                   fault
);

	logic [mem_pkg::BYTE_OFS_W-1:0] ofs;
	logic                           sz_byte;
	logic                           sz_half;
	logic                           sz_word;
	logic                           ok;        // Supported and aligned
	lsu_pkg::strb_t                 strb;
	lsu_pkg::mem_word_u             wd;
	lsu_pkg::mem_word_u             lane_wd;

	assign ofs = req_addr[mem_pkg::BYTE_OFS_W-1:0];
	assign wd  = req_wdata;

	// Width decode per funct3 and direction
	// Stores only know SB, SH and SW
	always_comb begin
		sz_byte = 1'b0;
		sz_half = 1'b0;
		sz_word = 1'b0;
		if (req_write) begin
			case (req_funct3)
				lsu_pkg::SB: sz_byte = 1'b1;
				lsu_pkg::SH: sz_half = 1'b1;
				lsu_pkg::SW: sz_word = 1'b1;
				default: ;              // Unsupported code
			endcase
		end else begin
			case (req_funct3)
				lsu_pkg::LB, lsu_pkg::LBU: sz_byte = 1'b1;
				lsu_pkg::LH, lsu_pkg::LHU: sz_half = 1'b1;
				lsu_pkg::LW:               sz_word = 1'b1;
				default: ;
			endcase
		end
	end

	// Halfword needs an even offset, word needs offset 0
	assign ok = sz_byte
	          | (sz_half && !ofs[0])
	          | (sz_word && (ofs == '0));

	// Lane strobes and lane placement of the store data
	always_comb begin
		strb         = '0;
		lane_wd.word = '0;
		if (sz_byte) begin
			strb                  = lsu_pkg::strb_t'(1) << ofs;
			lane_wd.bytes[ofs]    = wd.bytes[0];     // Low byte to addressed lane
		end else if (sz_half) begin
			strb                  = lsu_pkg::strb_t'(3) << ofs;
			lane_wd.halves[ofs[1]] = wd.halves[0];
		end else if (sz_word) begin
			strb         = '1;
			lane_wd.word = wd.word;
		end
	end

	// Control state updated every cycle so strobes never linger
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s1_strb  <= '0;
			fault    <= 1'b0;
		end else begin
			s1_valid <= req_valid && ok;
			fault    <= req_valid && !ok;                        // One-cycle pulse
			s1_strb  <= (req_valid && ok && req_write) ? strb : '0;
		end
	end

	// Payload captured with each request
	always_ff @(posedge clk) begin
		if (req_valid) begin
			s1_load      <= !req_write;
			s1_funct3    <= req_funct3;
			s1_lane      <= ofs;
			s1_word_addr <= req_addr[ADDR_W+mem_pkg::BYTE_OFS_W-1:mem_pkg::BYTE_OFS_W];
			s1_wdata     <= lane_wd.word;
		end
	end

	// A fault never comes with a write strobe
	a_fault_no_strb: assert property (@(posedge clk) disable iff (!rst_n)
		fault |-> (s1_strb == '0))
		else $error("store_align: fault with nonzero strobe %b", s1_strb);

endmodule

`default_nettype wire

/* logic/load_extract.sv */
`timescale 1ns/1ps
`default_nettype none

// Stage 3, lane select plus sign or zero extension
module load_extract (
	input  wire                             clk,
	input  wire                             rst_n,

	input  wire                             s1_valid,
	input  wire                             s1_load,
	input  wire  lsu_pkg::funct3_e          s1_funct3,
	input  wire  [mem_pkg::BYTE_OFS_W-1:0]  s1_lane,
	input  wire  [mem_pkg::WORD_W-1:0]      core_rdata,   // Combinational from datamem

	output logic                            rd_valid,
	output logic [mem_pkg::WORD_W-1:0]      rd_data
);

	localparam int BW = mem_pkg::BYTE_W;
	localparam int HW = 2 * mem_pkg::BYTE_W;

	lsu_pkg::mem_word_u   rw;
	logic [BW-1:0]        b;
	logic [HW-1:0]        h;
	logic [mem_pkg::WORD_W-1:0] ext;

	assign rw = core_rdata;
	assign b  = rw.bytes[s1_lane];
	assign h  = rw.halves[s1_lane[1]];   // Alignment already checked in stage 1

	always_comb begin
		case (s1_funct3)
			lsu_pkg::LB:  ext = {{(mem_pkg::WORD_W-BW){b[BW-1]}}, b};
			lsu_pkg::LBU: ext = {{(mem_pkg::WORD_W-BW){1'b0}}, b};
			lsu_pkg::LH:  ext = {{(mem_pkg::WORD_W-HW){h[HW-1]}}, h};
			lsu_pkg::LHU: ext = {{(mem_pkg::WORD_W-HW){1'b0}}, h};
			default:      ext = rw.word;                    // LW
		endcase
	end

	// Stores pass through stage 1 but never produce a result
	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= s1_valid && s1_load;
	end

	always_ff @(posedge clk) begin
		if (s1_valid && s1_load)
			rd_data <= ext;
	end

endmodule

`default_nettype wire

/* logic/mem_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Memory-access stage, aligner into memory into extractor
module mem_stage_top #(
	parameter int ADDR_W = mem_pkg::WORD_ADDR_W
) (
	input  wire                                    clk,
	input  wire                                    rst_n,

	// Core request
	input  wire                                    req_valid,
	input  wire                                    req_write,
	input  wire  lsu_pkg::funct3_e                 req_funct3,
	input  wire  [ADDR_W+mem_pkg::BYTE_OFS_W-1:0]  req_addr,
	input  wire  [mem_pkg::WORD_W-1:0]             req_wdata,

	// Load result and fault
	output logic                                   rd_valid,
	output logic [mem_pkg::WORD_W-1:0]             rd_data,
	output logic                                   fault,

	// Protocol controller port, straight into datamem
	input  wire  [ADDR_W-1:0]                      con_addr,
	input  wire  lsu_pkg::strb_t                   con_strb,
	input  wire  [mem_pkg::WORD_W-1:0]             con_wdata,
	output logic [mem_pkg::WORD_W-1:0]             con_rdata
);

	logic                           s1_valid;
	logic                           s1_load;
	lsu_pkg::funct3_e               s1_funct3;
	logic [mem_pkg::BYTE_OFS_W-1:0] s1_lane;
	logic [ADDR_W-1:0]              s1_word_addr;
	lsu_pkg::strb_t                 s1_strb;
	logic [mem_pkg::WORD_W-1:0]     s1_wdata;
	logic [mem_pkg::WORD_W-1:0]     core_rdata;

	store_align #(
		.ADDR_W (ADDR_W)
	) u_store_align (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_valid    (req_valid),
		.req_write    (req_write),
		.req_funct3   (req_funct3),
		.req_addr     (req_addr),
		.req_wdata    (req_wdata),
		.s1_valid     (s1_valid),
		.s1_load      (s1_load),
		.s1_funct3    (s1_funct3),
		.s1_lane      (s1_lane),
		.s1_word_addr (s1_word_addr),
		.s1_strb      (s1_strb),
		.s1_wdata     (s1_wdata),
		.fault        (fault)
	);

	datamem #(
		.ADDR_W (ADDR_W)
	) u_datamem (
		.clk        (clk),
		.core_addr  (s1_word_addr),
		.core_strb  (s1_strb),      // Zero for loads and faults
		.core_wdata (s1_wdata),
		.core_rdata (core_rdata),
		.con_addr   (con_addr),
		.con_strb   (con_strb),
		.con_wdata  (con_wdata),
		.con_rdata  (con_rdata)
	);

	load_extract u_load_extract (
		.clk        (clk),
		.rst_n      (rst_n),
		.s1_valid   (s1_valid),
		.s1_load    (s1_load),
		.s1_funct3  (s1_funct3),
		.s1_lane    (s1_lane),
		.core_rdata (core_rdata),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data)
	);

endmodule

`default_nettype wire

/* tb/tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

// Random-stimulus testbench for the memory-access stage
module tb_mem_stage;

	localparam int ADDR_W  = mem_pkg::WORD_ADDR_W;
	localparam int BA_W    = ADDR_W + mem_pkg::BYTE_OFS_W;   // Byte address width
	localparam int N_WORDS = 2 ** ADDR_W;

	// Operation counts per phase
	localparam int N_WORD_OPS  = 200;
	localparam int N_SUB_OPS   = 300;   // Store plus load each
	localparam int N_FAULT_OPS = 100;
	localparam int N_MIX_OPS   = 100;   // Four operations each
	localparam int TOTAL_OPS   = 2 * N_WORDS + N_WORD_OPS + 2 * N_SUB_OPS
	                           + N_FAULT_OPS + 4 * N_MIX_OPS;

	typedef logic [mem_pkg::WORD_W-1:0] word_t;
	typedef logic [BA_W-1:0]            baddr_t;
	typedef logic [ADDR_W-1:0]          waddr_t;

	logic             clk;
	logic             rst_n;
	logic             req_valid;
	logic             req_write;
	lsu_pkg::funct3_e req_funct3;
	baddr_t           req_addr;
	word_t            req_wdata;
	logic             rd_valid;
	word_t            rd_data;
	logic             fault;
	waddr_t           con_addr;
	lsu_pkg::strb_t   con_strb;
	word_t            con_wdata;
	word_t            con_rdata;

	word_t model [0:N_WORDS-1];   // Reference copy of the whole memory

	mem_stage_top #(
		.ADDR_W (ADDR_W)
	) dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_write  (req_write),
		.req_funct3 (req_funct3),
		.req_addr   (req_addr),
		.req_wdata  (req_wdata),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data),
		.fault      (fault),
		.con_addr   (con_addr),
		.con_strb   (con_strb),
		.con_wdata  (con_wdata),
		.con_rdata  (con_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns period
	end

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_load(input logic got_v, input word_t got,
			input logic exp_v, input word_t exp);
		if (got_v !== exp_v) begin
			$display("ERROR %0t: rd_valid got %b expected %b", $time, got_v, exp_v);
			abort_run();
		end
		if (exp_v && (got !== exp)) begin   // Data only matters with a result
			$display("ERROR %0t: rd_data got %h expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_con(input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERROR %0t: con_rdata got %h expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_fault(input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %0t: fault got %b expected %b", $time, got, exp);
			abort_run();
		end
	endtask

	// Bytes touched by an access, 0 when the code is not supported
	function automatic int access_size(input logic wr, input lsu_pkg::funct3_e f3);
		logic [2:0] code;
		code = f3;
		case (code)
			3'b000:  return 1;
			3'b001:  return 2;
			3'b010:  return 4;
			3'b100:  return wr ? 0 : 1;   // LBU, no store form
			3'b101:  return wr ? 0 : 2;   // LHU
			default: return 0;
		endcase
	endfunction

	function automatic logic fault_expected(input int sz, input logic [1:0] ofs);
		return (sz == 0) || (sz == 2 && ofs[0]) || (sz == 4 && ofs != 2'b00);
	endfunction

	// Lane merge of a store into the old word
	function automatic word_t store_merge(input word_t old, input int sz,
			input logic [1:0] ofs, input word_t wdata);
		word_t mask;
		case (sz)
			1:       mask = 32'h0000_00ff;
			2:       mask = 32'h0000_ffff;
			default: mask = 32'hffff_ffff;
		endcase
		mask = mask << {ofs, 3'b000};
		return (old & ~mask) | ((wdata << {ofs, 3'b000}) & mask);
	endfunction

	// Loaded value after lane pick and extension
	function automatic word_t load_value(input lsu_pkg::funct3_e f3, input word_t w,
			input logic [1:0] ofs);
		word_t sh;
		sh = w >> {ofs, 3'b000};   // Addressed lane down to bit 0
		case (f3)
			lsu_pkg::LB:  return {{24{sh[7]}}, sh[7:0]};
			lsu_pkg::LBU: return {24'h0, sh[7:0]};
			lsu_pkg::LH:  return {{16{sh[15]}}, sh[15:0]};
			lsu_pkg::LHU: return {16'h0, sh[15:0]};
			default:      return w;
		endcase
	endfunction

	function automatic logic [1:0] rand_ofs(input int sz);
		logic [1:0] o;
		o = 2'($urandom);
		if (sz == 2)
			o[0] = 1'b0;
		else if (sz == 4)
			o = 2'b00;
		return o;
	endfunction

	function automatic lsu_pkg::funct3_e pick_load_code();
		case ($urandom % 5)
			0:       return lsu_pkg::LB;
			1:       return lsu_pkg::LBU;
			2:       return lsu_pkg::LH;
			3:       return lsu_pkg::LHU;
			default: return lsu_pkg::LW;
		endcase
	endfunction

	// Single request, checked for fault, result and memory contents
	task automatic core_op(input logic wr, input lsu_pkg::funct3_e f3, input baddr_t addr,
			input word_t wdata);
		waddr_t     wa;
		logic [1:0] ofs;
		int         sz;
		logic       bad;
		word_t      exp_rd;
		wa     = addr[BA_W-1:mem_pkg::BYTE_OFS_W];
		ofs    = addr[mem_pkg::BYTE_OFS_W-1:0];
		sz     = access_size(wr, f3);
		bad    = fault_expected(sz, ofs);
		exp_rd = load_value(f3, model[wa], ofs);
		@(posedge clk);
		req_valid  <= 1'b1;
		req_write  <= wr;
		req_funct3 <= f3;
		req_addr   <= addr;
		req_wdata  <= wdata;
		con_addr   <= wa;            // Watch the same word on the other port
		@(posedge clk);
		req_valid  <= 1'b0;          // Sampled at this edge
		@(negedge clk);
		check_fault(fault, bad);
		if (wr && !bad)
			model[wa] = store_merge(model[wa], sz, ofs, wdata);
		@(posedge clk);
		@(negedge clk);
		check_load(rd_valid, rd_data, !wr && !bad, exp_rd);
		check_con(con_rdata, model[wa]);
	endtask

	// Store in one cycle, load of the same word in the next
	task automatic store_then_load(input lsu_pkg::funct3_e sf3, input baddr_t saddr,
			input word_t wdata, input lsu_pkg::funct3_e lf3, input logic [1:0] lofs);
		waddr_t wa;
		word_t  exp_rd;
		wa        = saddr[BA_W-1:mem_pkg::BYTE_OFS_W];
		model[wa] = store_merge(model[wa], access_size(1'b1, sf3), saddr[1:0], wdata);
		exp_rd    = load_value(lf3, model[wa], lofs);   // Must see the new data
		@(posedge clk);
		req_valid  <= 1'b1;
		req_write  <= 1'b1;
		req_funct3 <= sf3;
		req_addr   <= saddr;
		req_wdata  <= wdata;
		con_addr   <= wa;
		@(posedge clk);
		req_write  <= 1'b0;
		req_funct3 <= lf3;
		req_addr   <= {wa, lofs};
		@(negedge clk);
		check_fault(fault, 1'b0);
		@(posedge clk);
		req_valid  <= 1'b0;
		@(negedge clk);
		check_fault(fault, 1'b0);
		check_load(rd_valid, rd_data, 1'b0, exp_rd);   // Store gives no result
		@(posedge clk);
		@(negedge clk);
		check_load(rd_valid, rd_data, 1'b1, exp_rd);
		check_con(con_rdata, model[wa]);
	endtask

	task automatic con_write(input waddr_t wa, input lsu_pkg::strb_t strb, input word_t data);
		@(posedge clk);
		con_addr  <= wa;
		con_wdata <= data;
		con_strb  <= strb;
		@(posedge clk);
		con_strb  <= '0;             // Written at this edge
		for (int l = 0; l < mem_pkg::LANES; l++)
			if (strb[l])
				model[wa][8*l +: 8] = data[8*l +: 8];
	endtask

	task automatic con_read_back(input waddr_t wa);
		@(posedge clk);
		con_addr <= wa;
		@(negedge clk);
		check_con(con_rdata, model[wa]);
	endtask

	initial begin : watchdog
		repeat (TOTAL_OPS * 10 + 100) @(posedge clk);
		$display("Timeout, the test sequence did not finish in the expected number of cycles");
		abort_run();
	end

	initial begin : main
		int unsigned        r;
		baddr_t             a;
		waddr_t             wa;
		lsu_pkg::funct3_e   f3;
		lsu_pkg::funct3_e   lf3;
		logic               wr;
		lsu_pkg::strb_t     st;
		rst_n      = 1'b0;
		req_valid  = 1'b0;
		req_write  = 1'b0;
		req_funct3 = lsu_pkg::LB;
		req_addr   = '0;
		req_wdata  = '0;
		con_addr   = '0;
		con_strb   = '0;
		con_wdata  = '0;
		void'($urandom(32'h5b36));
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// Fill both banks through the controller port, then read back
		for (int i = 0; i < N_WORDS; i++)
			con_write(waddr_t'(i), 4'b1111, $urandom);
		for (int i = 0; i < N_WORDS; i++)
			con_read_back(waddr_t'(i));

		// Full words only
		for (int i = 0; i < N_WORD_OPS; i++) begin
			r = $urandom;
			a = baddr_t'($urandom);
			a[1:0] = 2'b00;
			core_op(r[0], r[0] ? lsu_pkg::SW : lsu_pkg::LW, a, $urandom);
		end

		// Sub-word store, then any load from the same word
		for (int i = 0; i < N_SUB_OPS; i++) begin
			r  = $urandom;
			f3 = r[0] ? lsu_pkg::SH : lsu_pkg::SB;
			wa = waddr_t'($urandom);
			core_op(1'b1, f3, {wa, rand_ofs(access_size(1'b1, f3))}, $urandom);
			lf3 = pick_load_code();
			core_op(1'b0, lf3, {wa, rand_ofs(access_size(1'b0, lf3))}, '0);
		end

		// Misaligned or unsupported, memory must stay put
		for (int i = 0; i < N_FAULT_OPS; i++) begin
			r  = $urandom;
			wr = r[0];
			a  = baddr_t'($urandom);
			case (r[4:1] % 3)
				0: begin
					f3   = lsu_pkg::LH;             // Same code as SH
					a[0] = 1'b1;
				end
				1: begin
					f3 = lsu_pkg::LW;
					if (a[1:0] == 2'b00)
						a[1:0] = 2'b10;
				end
				default: begin
					case (r[10:8] % 5)
						0:       f3 = lsu_pkg::funct3_e'(3'b011);
						1:       f3 = lsu_pkg::funct3_e'(3'b110);
						2:       f3 = lsu_pkg::funct3_e'(3'b111);
						3:       f3 = lsu_pkg::LBU;
						default: f3 = lsu_pkg::LHU;
					endcase
					if (f3 == lsu_pkg::LBU || f3 == lsu_pkg::LHU)
						wr = 1'b1;                      // Only bad as stores
				end
			endcase
			core_op(wr, f3, a, $urandom);
		end

		// Cross-port traffic and back-to-back store then load
		for (int i = 0; i < N_MIX_OPS; i++) begin
			r  = $urandom;
			wa = waddr_t'($urandom);
			case (r % 7)
				0:       st = 4'b0001;
				1:       st = 4'b0010;
				2:       st = 4'b0100;
				3:       st = 4'b1000;
				4:       st = 4'b0011;
				5:       st = 4'b1100;
				default: st = 4'b1111;
			endcase
			con_write(wa, st, $urandom);
			lf3 = pick_load_code();
			core_op(1'b0, lf3, {wa, rand_ofs(access_size(1'b0, lf3))}, '0);
			case (r[9:8])
				0:       f3 = lsu_pkg::SB;
				1:       f3 = lsu_pkg::SH;
				default: f3 = lsu_pkg::SW;
			endcase
			lf3 = pick_load_code();
			store_then_load(f3, {wa, rand_ofs(access_size(1'b1, f3))}, $urandom,
				lf3, rand_ofs(access_size(1'b0, lf3)));
		end

		repeat (2) @(posedge clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
common/mem_pkg.sv
common/lsu_pkg.sv
datamem/datamem.sv
logic/store_align.sv
logic/load_extract.sv
logic/mem_stage_top.sv
tb/tb_mem_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_stage \
	-f sim.f -o tb_mem_stage > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_mem_stage > sim.log 2>&1
cat sim.log

grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
